// ==== src/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;           // Data and address width
    localparam int imem_words = 64;     // Instruction memory depth
    localparam int dmem_words = 64;     // Data memory depth

    // Control and status register in the 12-bit APB space
    localparam logic [11:0] ctrl_addr = 12'h100;

    // Major opcodes, RV32I encoding
    typedef enum logic [6:0] {
        OP_R     = 7'b0110011,  // Register-register
        OP_IMM   = 7'b0010011,  // Register-immediate
        OP_LOAD  = 7'b0000011,  // LW
        OP_STORE = 7'b0100011   // SW
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

endpackage

// ==== src/decode_if.sv ====
`timescale 1ns/100ps

interface decode_if;

    logic [4:0]              rs1;         // Source register 1
    logic [4:0]              rs2;         // Source register 2
    logic [4:0]              rd;          // Destination register
    logic [rv_pkg::xlen-1:0] imm;         // Sign-extended immediate
    rv_pkg::alu_op_e         alu_op;
    logic                    use_imm;     // ALU operand b from imm
    logic                    reg_we;      // Register write, never for x0
    logic                    mem_we;      // SW
    logic                    mem_to_reg;  // LW result to register

    modport producer (
        output rs1, rs2, rd, imm, alu_op, use_imm, reg_we, mem_we, mem_to_reg
    );

    modport consumer (
        input rs1, rs2, rd, imm, alu_op, use_imm, reg_we, mem_we, mem_to_reg
    );

endinterface

// ==== src/apb_loader.sv ====
`timescale 1ns/100ps

module apb_loader (
    input  logic                                    CLK,
    input  logic                                    RST,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [11:0]                             paddr,
    input  logic [rv_pkg::xlen-1:0]                 pwdata,
    output logic [rv_pkg::xlen-1:0]                 prdata,
    output logic                                    pslverr,
    input  logic [rv_pkg::xlen-1:0]                 pc,
    input  logic [rv_pkg::xlen-1:0]                 load_rdata,
    output logic                                    run,
    output logic                                    load_we,
    output logic [$clog2(rv_pkg::imem_words)-1:0]   load_addr,
    output logic [rv_pkg::xlen-1:0]                 load_data
);

    localparam int imem_aw = $clog2(rv_pkg::imem_words);

    logic access;   // Access phase, completes this cycle
    logic is_imem;  // Instruction word window
    logic is_ctrl;

    assign access  = psel & penable;
    assign is_imem = (paddr < rv_pkg::ctrl_addr);
    assign is_ctrl = (paddr == rv_pkg::ctrl_addr);

    // Load port into instruction memory, only while stopped
    assign load_we   = access & pwrite & is_imem & ~run;
    assign load_addr = paddr[imem_aw+1:2];  // Byte address to word index
    assign load_data = pwdata;

    always_ff @(posedge CLK) begin
        if (RST) begin
            run <= 1'b0;
        end else if (access && pwrite && is_ctrl) begin
            run <= pwdata[0];
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (is_ctrl) begin
                prdata = {pc[rv_pkg::xlen-1:2], 1'b0, run};  // Status word
            end else if (is_imem) begin
                prdata = load_rdata;
            end
        end
    end

    // Refused load during run, or an unmapped address
    assign pslverr = access & ((is_imem & pwrite & run) | (~is_imem & ~is_ctrl));

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit (
    input  logic                                    CLK,
    input  logic                                    RST,
    input  logic                                    run,
    input  logic                                    load_we,
    input  logic [$clog2(rv_pkg::imem_words)-1:0]   load_addr,
    input  logic [rv_pkg::xlen-1:0]                 load_data,
    output logic [rv_pkg::xlen-1:0]                 load_rdata,
    output logic [rv_pkg::xlen-1:0]                 pc,
    output logic [rv_pkg::xlen-1:0]                 inst
);

    localparam int imem_aw = $clog2(rv_pkg::imem_words);
    localparam logic [rv_pkg::xlen-1:0] pc_last = (rv_pkg::imem_words - 1) * 4;

    logic [rv_pkg::xlen-1:0] imem [rv_pkg::imem_words];  // Program store
    logic [imem_aw-1:0]      pc_idx;

    assign pc_idx = pc[imem_aw+1:2];

    // Program counter, one word per running clock
    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else if (run) begin
            if (pc == pc_last) begin
                pc <= '0;  // Wrap at the end of memory
            end else begin
                pc <= pc + 4;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (load_we) begin
            imem[load_addr] <= load_data;
        end
    end

    // All-zero word decodes as no-op, so a stopped core writes nothing
    assign inst       = run ? imem[pc_idx] : '0;
    assign load_rdata = imem[load_addr];  // APB readback

endmodule

// ==== src/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
    input  logic [rv_pkg::xlen-1:0] inst,
    decode_if.producer              dec
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            f7_zero;  // funct7 = 0000000
    logic            f7_alt;   // funct7 = 0100000
    logic            valid;    // Supported instruction that writes rd
    rv_pkg::alu_op_e arith_op;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign f7_zero = (inst[31:25] == 7'b0000000);
    assign f7_alt  = (inst[31:25] == 7'b0100000);

    assign dec.rs1 = inst[19:15];
    assign dec.rs2 = inst[24:20];
    assign dec.rd  = inst[11:7];

    // funct3 to operation, SUB only for register-register
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (f7_alt && opcode == rv_pkg::OP_R) ? rv_pkg::ALU_SUB
                                                                   : rv_pkg::ALU_ADD;
            3'b001:  arith_op = rv_pkg::ALU_SLL;
            3'b010:  arith_op = rv_pkg::ALU_SLT;
            3'b011:  arith_op = rv_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_pkg::ALU_XOR;
            3'b101:  arith_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  arith_op = rv_pkg::ALU_OR;
            default: arith_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        valid          = 1'b0;
        dec.alu_op     = rv_pkg::ALU_ADD;  // Address add for loads and stores
        dec.use_imm    = 1'b0;
        dec.mem_we     = 1'b0;
        dec.mem_to_reg = 1'b0;
        dec.imm        = {{(rv_pkg::xlen-12){inst[31]}}, inst[31:20]};  // I immediate
        case (rv_pkg::opcode_e'(opcode))
            rv_pkg::OP_R: begin
                dec.alu_op = arith_op;
                valid = f7_zero | (f7_alt & (funct3 == 3'b000 | funct3 == 3'b101));
            end
            rv_pkg::OP_IMM: begin
                dec.alu_op  = arith_op;
                dec.use_imm = 1'b1;
                if (funct3 == 3'b001) begin
                    valid = f7_zero;  // SLLI
                end else if (funct3 == 3'b101) begin
                    valid = f7_zero | f7_alt;  // SRLI, SRAI
                end else begin
                    valid = 1'b1;
                end
            end
            rv_pkg::OP_LOAD: begin
                dec.use_imm    = 1'b1;
                dec.mem_to_reg = 1'b1;
                valid          = (funct3 == 3'b010);  // LW only
            end
            rv_pkg::OP_STORE: begin
                dec.use_imm = 1'b1;
                dec.imm     = {{(rv_pkg::xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
                dec.mem_we  = (funct3 == 3'b010);  // SW only
            end
            default: ;  // No-op
        endcase
        dec.reg_we = valid & (inst[11:7] != 5'd0);
    end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/100ps

module register_file (
    input  logic                    CLK,
    input  logic                    RST,
    decode_if.consumer              dec,
    input  logic [rv_pkg::xlen-1:0] wd,   // Write-back value
    output logic [rv_pkg::xlen-1:0] rd1,
    output logic [rv_pkg::xlen-1:0] rd2
);

    logic [rv_pkg::xlen-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (dec.reg_we && dec.rd != 5'd0) begin
            regs[dec.rd] <= wd;
        end
    end

    // Asynchronous reads, x0 reads as zero
    assign rd1 = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
    assign rd2 = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

endmodule

// ==== src/alu.sv ====
`timescale 1ns/100ps

module alu (
    decode_if.consumer              dec,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b_reg,
    output logic [rv_pkg::xlen-1:0] result
);

    logic [rv_pkg::xlen-1:0] b;
    logic [4:0]              shamt;

    assign b     = dec.use_imm ? dec.imm : b_reg;
    assign shamt = b[4:0];  // Low five bits only

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;
            rv_pkg::ALU_SLL:  result = a << shamt;
            rv_pkg::ALU_SLT:  result = {{(rv_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: result = {{(rv_pkg::xlen-1){1'b0}}, a < b};
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SRL:  result = a >> shamt;
            rv_pkg::ALU_SRA:  result = $signed(a) >>> shamt;  // Keeps the sign
            rv_pkg::ALU_OR:   result = a | b;
            default:          result = a & b;
        endcase
    end

endmodule

// ==== src/data_mem.sv ====
`timescale 1ns/100ps

module data_mem (
    input  logic                    CLK,
    decode_if.consumer              dec,
    input  logic [rv_pkg::xlen-1:0] addr,   // ALU result
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rdata   // Loaded word or ALU result
);

    localparam int dmem_aw = $clog2(rv_pkg::dmem_words);

    logic [rv_pkg::xlen-1:0] mem [rv_pkg::dmem_words];
    logic [dmem_aw-1:0]      idx;

    assign idx = addr[dmem_aw+1:2];  // Word index, wraps modulo depth

    always_ff @(posedge CLK) begin
        if (dec.mem_we) begin
            mem[idx] <= wdata;
        end
    end

    // Write-back select
    assign rdata = dec.mem_to_reg ? mem[idx] : addr;

endmodule

// ==== src/single_cpu.sv ====
`timescale 1ns/100ps

module single_cpu (
    input  logic        CLK,
    input  logic        RST,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);

    localparam int imem_aw = $clog2(rv_pkg::imem_words);

    logic                    run;
    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] inst;
    logic                    load_we;
    logic [imem_aw-1:0]      load_addr;
    logic [rv_pkg::xlen-1:0] load_data;
    logic [rv_pkg::xlen-1:0] load_rdata;
    logic [rv_pkg::xlen-1:0] rd1;
    logic [rv_pkg::xlen-1:0] rd2;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic [rv_pkg::xlen-1:0] wb_wd;  // Value written back this cycle

    decode_if dec_bus ();

    apb_loader u_loader (
        .CLK(CLK), .RST(RST),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
        .pc(pc), .load_rdata(load_rdata), .run(run),
        .load_we(load_we), .load_addr(load_addr), .load_data(load_data)
    );

    fetch_unit u_fetch (
        .CLK(CLK), .RST(RST), .run(run),
        .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
        .load_rdata(load_rdata), .pc(pc), .inst(inst)
    );

    inst_decoder u_decoder (.inst(inst), .dec(dec_bus.producer));

    register_file u_regs (
        .CLK(CLK), .RST(RST), .dec(dec_bus.consumer),
        .wd(wb_wd), .rd1(rd1), .rd2(rd2)
    );

    alu u_alu (.dec(dec_bus.consumer), .a(rd1), .b_reg(rd2), .result(alu_result));

    data_mem u_dmem (
        .CLK(CLK), .dec(dec_bus.consumer),
        .addr(alu_result), .wdata(rd2), .rdata(wb_wd)
    );

    // Retire trace
    assign wb_valid = dec_bus.reg_we;
    assign wb_rd    = dec_bus.rd;
    assign wb_data  = wb_wd;

endmodule

// ==== verif/single_cpu_properties.sv ====
`timescale 1ns/100ps

module single_cpu_properties (
    input logic        CLK,
    input logic        RST,
    input logic        psel,
    input logic        penable,
    input logic        pslverr,
    input logic        wb_valid,
    input logic [4:0]  wb_rd,
    input logic        run,
    input logic [31:0] pc
);

    localparam logic [31:0] imem_bytes = rv_pkg::imem_words * 4;

    rd_nonzero: assert property (@(posedge CLK) disable iff (RST)
        wb_valid |-> wb_rd != 5'd0)
        else $error("Retire event reports rd zero");

    quiet_when_stopped: assert property (@(posedge CLK) disable iff (RST)
        !run |-> !wb_valid)
        else $error("Retire event while the core is stopped");

    // Access phase must follow a setup phase
    err_in_access: assert property (@(posedge CLK) disable iff (RST)
        pslverr |-> psel && penable && $past(psel && !penable))
        else $error("pslverr outside an access phase");

    pc_steps: assert property (@(posedge CLK) disable iff (RST)
        run |=> pc == ($past(pc) + 32'd4) % imem_bytes)  // Wraps at the end of memory
        else $error("pc did not step by one word");

    pc_holds: assert property (@(posedge CLK) disable iff (RST)
        !run |=> pc == $past(pc))
        else $error("pc moved while the core is stopped");

endmodule

bind single_cpu single_cpu_properties u_props (
    .CLK(CLK), .RST(RST), .psel(psel), .penable(penable), .pslverr(pslverr),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .run(run), .pc(pc)
);

// ==== verif/tb_single_cpu.sv ====
`timescale 1ns/100ps

module tb_single_cpu;

    localparam int wait_limit = 16;  // Cycles allowed per retire event

    logic                    CLK;
    logic                    RST;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [11:0]             paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pslverr;
    logic                    wb_valid;
    logic [4:0]              wb_rd;
    logic [31:0]             wb_data;

    logic [rv_pkg::xlen-1:0] prog [$];
    logic [rv_pkg::xlen-1:0] image [rv_pkg::imem_words];  // Expected instruction memory
    logic [4:0]              exp_rd [$];
    logic [rv_pkg::xlen-1:0] exp_data [$];
    logic [11:0]             refused_addr;
    logic [31:0]             refused_data;
    logic [31:0]             exp_status;
    logic [31:0]             rng_state;
    int                      nop_count;
    int                      errors;
    int                      timeouts;

    single_cpu dut0 (
        .CLK(CLK), .RST(RST), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    always #5 CLK = ~CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_word(input logic [rv_pkg::xlen-1:0] got,
                              input logic [rv_pkg::xlen-1:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input logic [4:0] got, input logic [4:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic read_patterns(input int fd);
        logic [63:0]   tag;
        logic [1023:0] line;
        logic [31:0]   word;
        logic [31:0]   data;
        int            rd;
        int            code;
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end else if (tag == "#") begin
                code = $fgets(line, fd);  // Rest of a comment line
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h %d %h", word, rd, data);
                prog.push_back(word);
                if (rd == 0) begin
                    nop_count++;
                end else begin
                    exp_rd.push_back(5'(rd));
                    exp_data.push_back(data);
                end
            end else if (tag == "W") begin
                code = $fscanf(fd, "%h %h", word, data);
                refused_addr = word[11:0];
                refused_data = data;
            end else if (tag == "S") begin
                code = $fscanf(fd, "%h", exp_status);
            end else begin
                $display("Unknown line tag in the pattern file");
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // One zero-wait transfer, setup then access, bus idle afterwards
    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge CLK);
        penable = 1'b1;
        @(posedge CLK);
        rdata = prdata;  // Still the access phase value
        err   = pslverr;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic idle_gap();
        rng_state = xorshift32(rng_state);
        repeat (rng_state % 4) @(negedge CLK);
    endtask

    task automatic load_program();
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < rv_pkg::imem_words; i++) begin
            image[i] = (i < prog.size()) ? prog[i] : ((i << 20) | 32'h93);  // ADDI x1, x0, i
            apb_transfer(1'b1, 12'(i * 4), image[i], rdata, err);
            check_err(err, 1'b0, "pslverr on load");
            idle_gap();
        end
        for (int i = 0; i < rv_pkg::imem_words; i++) begin
            apb_transfer(1'b0, 12'(i * 4), '0, rdata, err);
            check_word(rdata, image[i], "readback word");
            check_err(err, 1'b0, "pslverr on readback");
            idle_gap();
        end
        apb_transfer(1'b0, 12'h104, '0, rdata, err);
        check_err(err, 1'b1, "pslverr on unmapped read");
    endtask

    task automatic check_retires();
        logic seen;
        for (int i = 0; i < exp_rd.size(); i++) begin
            seen = 1'b0;
            for (int c = 0; c < wait_limit && !seen; c++) begin
                @(posedge CLK);
                seen = wb_valid;
            end
            if (seen) begin
                check_reg(wb_rd, exp_rd[i], "wb_rd");
                check_word(wb_data, exp_data[i], "wb_data");
            end else begin
                $display("Timed out waiting for retire event %0d", i);
                timeouts++;
            end
        end
    endtask

    task automatic run_program();
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, rv_pkg::ctrl_addr, 32'd1, rdata, err);
        fork
            check_retires();
            begin
                apb_transfer(1'b1, refused_addr, refused_data, rdata, err);
                check_err(err, 1'b1, "pslverr on load while running");
            end
        join
        // Two more instructions execute before the stop takes effect
        apb_transfer(1'b1, rv_pkg::ctrl_addr, 32'd0, rdata, err);
        for (int i = 0; i < 8; i++) begin
            @(posedge CLK);
            check_valid(wb_valid, 1'b0, "wb_valid after stop");
        end
        apb_transfer(1'b0, rv_pkg::ctrl_addr, '0, rdata, err);
        check_word(rdata, exp_status, "status word");
        check_word({rdata[31:2], 2'b00}, 32'(4 * (exp_rd.size() + nop_count)), "pc");
        apb_transfer(1'b0, refused_addr, '0, rdata, err);
        check_word(rdata, image[refused_addr / 4], "word after refused load");
        check_err(err, 1'b0, "pslverr on readback");
    endtask

    initial begin
        int fd;
        CLK          = 1'b0;
        RST          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        rng_state    = 32'd6;
        nop_count    = 0;
        errors       = 0;
        timeouts     = 0;
        fd = $fopen("verif/single_cpu_patterns.txt", "r");
        repeat (5) @(negedge CLK);
        RST = 1'b0;
        if (fd == 0) begin
            $display("Could not open the pattern file");
            errors++;
        end else begin
            read_patterns(fd);
            load_program();
            run_program();
        end
        $display("Done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== single_cpu.f ====
src/rv_pkg.sv
src/decode_if.sv
src/apb_loader.sv
src/fetch_unit.sv
src/inst_decoder.sv
src/register_file.sv
src/alu.sv
src/data_mem.sv
src/single_cpu.sv
verif/single_cpu_properties.sv
verif/tb_single_cpu.sv

// ==== Bender.yml ====
package:
  name: single_cpu

sources:
  - files:
      - src/rv_pkg.sv
      - src/decode_if.sv
      - src/apb_loader.sv
      - src/fetch_unit.sv
      - src/inst_decoder.sv
      - src/register_file.sv
      - src/alu.sv
      - src/data_mem.sv
      - src/single_cpu.sv
  - target: simulation
    files:
      - verif/single_cpu_properties.sv
      - verif/tb_single_cpu.sv

// ==== verif/single_cpu_patterns.txt ====
# I: program word, retire rd in decimal (0 when nothing retires), retire data
# W: address and data of the load refused while running; S: status word after stop
I 00500093 1 00000005
I FFD00113 2 FFFFFFFD
I 002081B3 3 00000002
I 40110233 4 FFFFFFF8
I 403252B3 5 FFFFFFFE
I 00325333 6 3FFFFFFE
I 001123B3 7 00000001
I 00113433 8 00000000
I FFF0C493 9 FFFFFFFA
I 00409513 10 00000050
I 40125593 11 FFFFFFFC
I 00F56613 12 0000005F
I 0F04F693 13 000000F0
I FFE12713 14 00000001
I 00452423 0 00000000
I 00852783 15 FFFFFFF8
I 00108033 0 00000000
I 00D67833 16 00000050
I 003868B3 17 00000052
I 0018C933 18 00000057
I 003099B3 19 00000014
I 00000013 0 00000000
I 00000013 0 00000000
W 054 00100093
S 0000005C
